//--- verilog/riscv_isa_pkg.sv
package riscv_isa_pkg;

    // base opcodes handled by the decoder
    localparam logic [6:0] OP_LOAD   = 7'b0000011;  // lw
    localparam logic [6:0] OP_STORE  = 7'b0100011;  // sw
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;  // beq only
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;

    // immediate formats
    localparam logic [2:0] IMM_I = 3'd0;
    localparam logic [2:0] IMM_S = 3'd1;
    localparam logic [2:0] IMM_B = 3'd2;
    localparam logic [2:0] IMM_J = 3'd3;
    localparam logic [2:0] IMM_U = 3'd4;

    localparam logic [1:0] ALUOP_ADD   = 2'd0;
    localparam logic [1:0] ALUOP_SUB   = 2'd1;
    localparam logic [1:0] ALUOP_FUNCT = 2'd2;  // look at funct3/funct7
    localparam logic [1:0] ALUOP_PASSB = 2'd3;  // lui

    localparam logic [3:0] ALU_ADD   = 4'd0;
    localparam logic [3:0] ALU_SUB   = 4'd1;
    localparam logic [3:0] ALU_SLL   = 4'd2;
    localparam logic [3:0] ALU_SLT   = 4'd3;
    localparam logic [3:0] ALU_XOR   = 4'd4;
    localparam logic [3:0] ALU_SRL   = 4'd5;
    localparam logic [3:0] ALU_SRA   = 4'd6;
    localparam logic [3:0] ALU_OR    = 4'd7;
    localparam logic [3:0] ALU_AND   = 4'd8;
    localparam logic [3:0] ALU_PASSB = 4'd9;

    localparam logic [1:0] RES_ALU = 2'd0;
    localparam logic [1:0] RES_MEM = 2'd1;
    localparam logic [1:0] RES_PC4 = 2'd2;  // link address

    localparam logic [1:0] JMP_NONE = 2'd0;
    localparam logic [1:0] JMP_JAL  = 2'd1;
    localparam logic [1:0] JMP_JALR = 2'd2;

    typedef struct packed {
        logic       branch;
        logic [1:0] jump;
        logic [1:0] result_src;
        logic       mem_write;
        logic       alu_src;
        logic [2:0] imm_src;
        logic       reg_write;
        logic [1:0] alu_op;
    } main_ctrl_t;

endpackage

//--- verilog/decode_pkg.sv
package decode_pkg;

    localparam int NUM_LANES  = 4;
    localparam int LANE_IDX_W = 2;

    // wrap point for the round-robin pointers
    localparam logic [LANE_IDX_W-1:0] LAST_LANE = LANE_IDX_W'(NUM_LANES - 1);

    // one decoded instruction as it leaves a lane and the unit
    typedef struct packed {
        logic        branch;
        logic [1:0]  jump;
        logic [1:0]  result_src;
        logic        mem_write;
        logic        alu_src;
        logic        reg_write;
        logic [3:0]  alu_ctrl;
        logic [31:0] imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
    } ctrl_word_t;

endpackage

//--- verilog/main_decoder.sv
module main_decoder (
    input  logic [6:0]               op_i,
    output riscv_isa_pkg::main_ctrl_t ctrl_o
);

    always_comb begin
        // register operation settings, also taken by unknown opcodes
        ctrl_o.branch     = 1'b0;
        ctrl_o.jump       = riscv_isa_pkg::JMP_NONE;
        ctrl_o.result_src = riscv_isa_pkg::RES_ALU;
        ctrl_o.mem_write  = 1'b0;
        ctrl_o.alu_src    = 1'b0;
        ctrl_o.imm_src    = riscv_isa_pkg::IMM_I;    // don't care here
        ctrl_o.reg_write  = 1'b1;
        ctrl_o.alu_op     = riscv_isa_pkg::ALUOP_FUNCT;

        case (op_i)
            riscv_isa_pkg::OP_LOAD: begin
                ctrl_o.result_src = riscv_isa_pkg::RES_MEM;
                ctrl_o.alu_src    = 1'b1;
                ctrl_o.alu_op     = riscv_isa_pkg::ALUOP_ADD;  // address calc
            end

            riscv_isa_pkg::OP_STORE: begin
                ctrl_o.reg_write = 1'b0;
                ctrl_o.mem_write = 1'b1;
                ctrl_o.alu_src   = 1'b1;
                ctrl_o.imm_src   = riscv_isa_pkg::IMM_S;
                ctrl_o.alu_op    = riscv_isa_pkg::ALUOP_ADD;
            end

            riscv_isa_pkg::OP_REG: begin
                // defaults already describe it
            end

            riscv_isa_pkg::OP_BRANCH: begin
                ctrl_o.branch    = 1'b1;
                ctrl_o.reg_write = 1'b0;
                ctrl_o.imm_src   = riscv_isa_pkg::IMM_B;
                ctrl_o.alu_op    = riscv_isa_pkg::ALUOP_SUB;  // compare by subtract
            end

            riscv_isa_pkg::OP_IMM: begin
                ctrl_o.alu_src = 1'b1;
            end

            riscv_isa_pkg::OP_JAL: begin
                ctrl_o.jump       = riscv_isa_pkg::JMP_JAL;
                ctrl_o.result_src = riscv_isa_pkg::RES_PC4;
                ctrl_o.imm_src    = riscv_isa_pkg::IMM_J;
                ctrl_o.alu_op     = riscv_isa_pkg::ALUOP_ADD;  // unused by jal
            end

            riscv_isa_pkg::OP_JALR: begin
                ctrl_o.jump       = riscv_isa_pkg::JMP_JALR;
                ctrl_o.result_src = riscv_isa_pkg::RES_PC4;
                ctrl_o.alu_src    = 1'b1;
            end

            riscv_isa_pkg::OP_LUI: begin
                ctrl_o.alu_src = 1'b1;
                ctrl_o.imm_src = riscv_isa_pkg::IMM_U;
                ctrl_o.alu_op  = riscv_isa_pkg::ALUOP_PASSB;
            end

            default: begin
                // no trap, falls back to register op
            end
        endcase
    end

endmodule

//--- verilog/alu_decoder.sv
module alu_decoder (
    input  logic [1:0] alu_op_i,
    input  logic [2:0] funct3_i,
    input  logic       funct7b5_i,
    input  logic       op5_i,     // set for register ops, clear for immediates
    output logic [3:0] alu_ctrl_o
);

    always_comb begin
        case (alu_op_i)
            riscv_isa_pkg::ALUOP_ADD:   alu_ctrl_o = riscv_isa_pkg::ALU_ADD;
            riscv_isa_pkg::ALUOP_SUB:   alu_ctrl_o = riscv_isa_pkg::ALU_SUB;
            riscv_isa_pkg::ALUOP_PASSB: alu_ctrl_o = riscv_isa_pkg::ALU_PASSB;
            default: begin
                case (funct3_i)
                    3'b000: begin
                        // addi has no sub form
                        if (funct7b5_i && op5_i) begin
                            alu_ctrl_o = riscv_isa_pkg::ALU_SUB;
                        end else begin
                            alu_ctrl_o = riscv_isa_pkg::ALU_ADD;
                        end
                    end
                    3'b001:  alu_ctrl_o = riscv_isa_pkg::ALU_SLL;
                    3'b010:  alu_ctrl_o = riscv_isa_pkg::ALU_SLT;
                    3'b100:  alu_ctrl_o = riscv_isa_pkg::ALU_XOR;
                    3'b101:  alu_ctrl_o = funct7b5_i ? riscv_isa_pkg::ALU_SRA
                                                     : riscv_isa_pkg::ALU_SRL;
                    3'b110:  alu_ctrl_o = riscv_isa_pkg::ALU_OR;
                    3'b111:  alu_ctrl_o = riscv_isa_pkg::ALU_AND;
                    default: alu_ctrl_o = riscv_isa_pkg::ALU_ADD;  // sltu not supported
                endcase
            end
        endcase
    end

endmodule

//--- verilog/imm_extender.sv
module imm_extender (
    input  logic [31:0] instr_i,
    input  logic [2:0]  imm_src_i,
    output logic [31:0] imm_o
);

    logic sign;

    assign sign = instr_i[31];

    always_comb begin
        case (imm_src_i)
            riscv_isa_pkg::IMM_I:
                imm_o = {{20{sign}}, instr_i[31:20]};
            riscv_isa_pkg::IMM_S:
                imm_o = {{20{sign}}, instr_i[31:25], instr_i[11:7]};
            riscv_isa_pkg::IMM_B:   // halfword offset, lsb always zero
                imm_o = {{19{sign}}, instr_i[31], instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            riscv_isa_pkg::IMM_J:
                imm_o = {{11{sign}}, instr_i[31], instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            riscv_isa_pkg::IMM_U:
                imm_o = {instr_i[31:12], 12'b0};
            default:
                imm_o = 32'b0;
        endcase
    end

endmodule

//--- verilog/decode_lane.sv
module decode_lane (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   load_i,
    input  logic [31:0]            instr_i,
    input  logic                   release_i,
    output logic                   busy_o,
    output logic                   done_o,
    output decode_pkg::ctrl_word_t ctrl_o
);

    logic [31:0]               instr_q;
    logic                      busy_q;
    logic                      done_q;
    decode_pkg::ctrl_word_t    ctrl_q;
    decode_pkg::ctrl_word_t    ctrl_d;
    riscv_isa_pkg::main_ctrl_t main_ctrl;
    logic [3:0]                alu_ctrl;
    logic [31:0]               imm;

    main_decoder u_main_dec (
        .op_i   (instr_q[6:0]),
        .ctrl_o (main_ctrl)
    );

    alu_decoder u_alu_dec (
        .alu_op_i   (main_ctrl.alu_op),
        .funct3_i   (instr_q[14:12]),
        .funct7b5_i (instr_q[30]),
        .op5_i      (instr_q[5]),
        .alu_ctrl_o (alu_ctrl)
    );

    imm_extender u_imm_ext (
        .instr_i   (instr_q),
        .imm_src_i (main_ctrl.imm_src),
        .imm_o     (imm)
    );

    always_comb begin
        ctrl_d.branch     = main_ctrl.branch;
        ctrl_d.jump       = main_ctrl.jump;
        ctrl_d.result_src = main_ctrl.result_src;
        ctrl_d.mem_write  = main_ctrl.mem_write;
        ctrl_d.alu_src    = main_ctrl.alu_src;
        ctrl_d.reg_write  = main_ctrl.reg_write;
        ctrl_d.alu_ctrl   = alu_ctrl;
        ctrl_d.imm        = imm;
        ctrl_d.rd         = instr_q[11:7];
        ctrl_d.rs1        = instr_q[19:15];
        ctrl_d.rs2        = instr_q[24:20];
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else if (release_i) begin    // collector took the word
            busy_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            if (load_i) begin
                busy_q <= 1'b1;
            end
            if (busy_q && !done_q) begin
                done_q <= 1'b1;              // result slot filled this edge
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            instr_q <= instr_i;
        end
        if (busy_q && !done_q) begin
            ctrl_q <= ctrl_d;
        end
    end

    assign busy_o = busy_q;
    assign done_o = done_q;
    assign ctrl_o = ctrl_q;

endmodule

//--- verilog/instr_dispatcher.sv
module instr_dispatcher (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             in_req_i,
    input  logic [31:0]                      in_instr_i,
    output logic                             in_ack_o,
    input  logic [decode_pkg::NUM_LANES-1:0] lane_busy_i,
    output logic [decode_pkg::NUM_LANES-1:0] lane_load_o,
    output logic [31:0]                      lane_instr_o
);

    logic [decode_pkg::LANE_IDX_W-1:0] ptr_q;   // next lane in program order
    logic                              ack_q;
    logic                              take;

    // only the lane at the pointer may take the word, keeps order
    assign take = !ack_q && in_req_i && !lane_busy_i[ptr_q];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ack_q       <= 1'b0;
            ptr_q       <= '0;
            lane_load_o <= '0;
        end else begin
            lane_load_o <= '0;                  // strobe
            if (take) begin
                ack_q              <= 1'b1;
                lane_load_o[ptr_q] <= 1'b1;
                ptr_q              <= (ptr_q == decode_pkg::LAST_LANE) ? '0 : ptr_q + 1'b1;
            end else if (ack_q && !in_req_i) begin
                ack_q <= 1'b0;                  // phase 4
            end
        end
    end

    // source may change data once it sees ack, so hold a copy for the lane
    always_ff @(posedge clk_i) begin
        if (take) begin
            lane_instr_o <= in_instr_i;
        end
    end

    assign in_ack_o = ack_q;

endmodule

//--- verilog/ctrl_collector.sv
module ctrl_collector (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic [decode_pkg::NUM_LANES-1:0] lane_done_i,
    input  decode_pkg::ctrl_word_t           lane_ctrl_i [decode_pkg::NUM_LANES],
    output logic [decode_pkg::NUM_LANES-1:0] lane_release_o,
    output logic                             out_req_o,
    output decode_pkg::ctrl_word_t           out_ctrl_o,
    input  logic                             out_ack_i
);

    logic [decode_pkg::LANE_IDX_W-1:0] ptr_q;
    logic                              req_q;
    logic                              wait_low_q;  // ack still high after req dropped
    logic                              grab;

    // port idle means neither req nor ack is up
    assign grab = !req_q && !wait_low_q && !out_ack_i && lane_done_i[ptr_q];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            req_q          <= 1'b0;
            wait_low_q     <= 1'b0;
            ptr_q          <= '0;
            lane_release_o <= '0;
        end else begin
            lane_release_o <= '0;
            if (req_q) begin
                if (out_ack_i) begin
                    req_q                 <= 1'b0;
                    wait_low_q            <= 1'b1;
                    lane_release_o[ptr_q] <= 1'b1;  // lane is free again
                end
            end else if (wait_low_q) begin
                if (!out_ack_i) begin
                    wait_low_q <= 1'b0;
                    ptr_q      <= (ptr_q == decode_pkg::LAST_LANE) ? '0 : ptr_q + 1'b1;
                end
            end else if (grab) begin
                req_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (grab) begin
            out_ctrl_o <= lane_ctrl_i[ptr_q];   // stable for whole handshake
        end
    end

    assign out_req_o = req_q;

endmodule

//--- verilog/decode_unit_top.sv
module decode_unit_top (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   in_req_i,
    input  logic [31:0]            in_instr_i,
    output logic                   in_ack_o,
    output logic                   out_req_o,
    output decode_pkg::ctrl_word_t out_ctrl_o,
    input  logic                   out_ack_i
);

    logic [decode_pkg::NUM_LANES-1:0] lane_busy;
    logic [decode_pkg::NUM_LANES-1:0] lane_load;
    logic [decode_pkg::NUM_LANES-1:0] lane_done;
    logic [decode_pkg::NUM_LANES-1:0] lane_release;
    logic [31:0]                      lane_instr;   // shared, qualified by lane_load
    decode_pkg::ctrl_word_t           lane_ctrl [decode_pkg::NUM_LANES];

    instr_dispatcher u_dispatch (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .in_req_i     (in_req_i),
        .in_instr_i   (in_instr_i),
        .in_ack_o     (in_ack_o),
        .lane_busy_i  (lane_busy),
        .lane_load_o  (lane_load),
        .lane_instr_o (lane_instr)
    );

    for (genvar i = 0; i < decode_pkg::NUM_LANES; i++) begin : g_lane
        decode_lane u_lane (
            .clk_i     (clk_i),
            .rst_n_i   (rst_n_i),
            .load_i    (lane_load[i]),
            .instr_i   (lane_instr),
            .release_i (lane_release[i]),
            .busy_o    (lane_busy[i]),
            .done_o    (lane_done[i]),
            .ctrl_o    (lane_ctrl[i])
        );
    end

    ctrl_collector u_collect (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .lane_done_i    (lane_done),
        .lane_ctrl_i    (lane_ctrl),
        .lane_release_o (lane_release),
        .out_req_o      (out_req_o),
        .out_ctrl_o     (out_ctrl_o),
        .out_ack_i      (out_ack_i)
    );

endmodule

//--- verif/decode_ref_model.svh
`ifndef DECODE_REF_MODEL_SVH
`define DECODE_REF_MODEL_SVH

// immediate rebuilt from arithmetic shifts of the whole word
function automatic logic [31:0] imm_for_opcode(input logic [31:0] instr);
    logic signed [31:0] s;
    logic [31:0]        sh11;
    logic [31:0]        sh19;
    logic [31:0]        sh20;
    s    = $signed(instr);
    sh11 = s >>> 11;    // sign bit fills the top
    sh19 = s >>> 19;
    sh20 = s >>> 20;
    case (instr[6:0])
        riscv_isa_pkg::OP_STORE:
            return (sh20 & 32'hFFFF_FFE0) | {27'b0, instr[11:7]};
        riscv_isa_pkg::OP_BRANCH:
            return (sh19 & 32'hFFFF_F000) | (32'(instr[7]) << 11)
                 | (32'(instr[30:25]) << 5) | (32'(instr[11:8]) << 1);
        riscv_isa_pkg::OP_JAL:
            return (sh11 & 32'hFFF0_0000) | (instr & 32'h000F_F000)
                 | (32'(instr[20]) << 11) | (32'(instr[30:21]) << 1);
        riscv_isa_pkg::OP_LUI:
            return instr & 32'hFFFF_F000;
        default:
            return sh20;    // I format for reg ops and unknown opcodes too
    endcase
endfunction

// funct3 / funct7 table for the funct ALU op
function automatic logic [3:0] funct_alu_code(input logic [31:0] instr);
    case (instr[14:12])
        3'd0: return (instr[30] && instr[5]) ? riscv_isa_pkg::ALU_SUB : riscv_isa_pkg::ALU_ADD;
        3'd1: return riscv_isa_pkg::ALU_SLL;
        3'd2: return riscv_isa_pkg::ALU_SLT;
        3'd4: return riscv_isa_pkg::ALU_XOR;
        3'd5: return instr[30] ? riscv_isa_pkg::ALU_SRA : riscv_isa_pkg::ALU_SRL;
        3'd6: return riscv_isa_pkg::ALU_OR;
        3'd7: return riscv_isa_pkg::ALU_AND;
        default: return riscv_isa_pkg::ALU_ADD;
    endcase
endfunction

function automatic decode_pkg::ctrl_word_t ref_decode(input logic [31:0] instr);
    decode_pkg::ctrl_word_t w;
    // start from a register operation
    w.branch     = 1'b0;
    w.jump       = riscv_isa_pkg::JMP_NONE;
    w.result_src = riscv_isa_pkg::RES_ALU;
    w.mem_write  = 1'b0;
    w.alu_src    = 1'b0;
    w.reg_write  = 1'b1;
    w.alu_ctrl   = funct_alu_code(instr);
    w.imm        = imm_for_opcode(instr);
    w.rd         = instr[11:7];
    w.rs1        = instr[19:15];
    w.rs2        = instr[24:20];
    case (instr[6:0])
        riscv_isa_pkg::OP_LOAD: begin
            w.result_src = riscv_isa_pkg::RES_MEM;
            w.alu_src    = 1'b1;
            w.alu_ctrl   = riscv_isa_pkg::ALU_ADD;
        end
        riscv_isa_pkg::OP_STORE: begin
            w.reg_write = 1'b0;
            w.mem_write = 1'b1;
            w.alu_src   = 1'b1;
            w.alu_ctrl  = riscv_isa_pkg::ALU_ADD;
        end
        riscv_isa_pkg::OP_BRANCH: begin
            w.branch    = 1'b1;
            w.reg_write = 1'b0;
            w.alu_ctrl  = riscv_isa_pkg::ALU_SUB;
        end
        riscv_isa_pkg::OP_IMM: w.alu_src = 1'b1;
        riscv_isa_pkg::OP_JAL: begin
            w.jump       = riscv_isa_pkg::JMP_JAL;
            w.result_src = riscv_isa_pkg::RES_PC4;
            w.alu_ctrl   = riscv_isa_pkg::ALU_ADD;
        end
        riscv_isa_pkg::OP_JALR: begin
            w.jump       = riscv_isa_pkg::JMP_JALR;
            w.result_src = riscv_isa_pkg::RES_PC4;
            w.alu_src    = 1'b1;     // alu code still follows funct3
        end
        riscv_isa_pkg::OP_LUI: begin
            w.alu_src  = 1'b1;
            w.alu_ctrl = riscv_isa_pkg::ALU_PASSB;
        end
        default: w.reg_write = 1'b1;
    endcase
    return w;
endfunction

`endif

//--- verif/decode_unit_tb.sv
module decode_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 8;
    localparam int N_RANDOM    = 200;
    localparam int N_UNKNOWN   = 20;
    localparam int N_BURST     = 40;
    localparam int TOTAL_INSTR = 8 + 32 + N_RANDOM + N_UNKNOWN + N_BURST;
    localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 40 + 200;

    logic                   clk_i = 1'b0;
    logic                   rst_n_i;
    logic                   in_req_i;
    logic [31:0]            in_instr_i;
    logic                   in_ack_o;
    logic                   out_req_o;
    decode_pkg::ctrl_word_t out_ctrl_o;
    logic                   out_ack_i;

    decode_pkg::ctrl_word_t exp_q[$];   // scoreboard, program order
    integer stim_seed = 32'h2841_c7c2;
    integer ack_seed  = 32'h2841_c7c2;
    int     max_ack_delay = 6;
    int     sent = 0;
    int     received = 0;

    `include "decode_ref_model.svh"

    decode_unit_top dut0 (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .in_req_i   (in_req_i),
        .in_instr_i (in_instr_i),
        .in_ack_o   (in_ack_o),
        .out_req_o  (out_req_o),
        .out_ctrl_o (out_ctrl_o),
        .out_ack_i  (out_ack_i)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    function automatic logic [6:0] supported_op(input int idx);
        case (idx)
            0: return riscv_isa_pkg::OP_LOAD;
            1: return riscv_isa_pkg::OP_STORE;
            2: return riscv_isa_pkg::OP_BRANCH;
            3: return riscv_isa_pkg::OP_IMM;
            4: return riscv_isa_pkg::OP_JAL;
            5: return riscv_isa_pkg::OP_JALR;
            6: return riscv_isa_pkg::OP_LUI;
            default: return riscv_isa_pkg::OP_REG;
        endcase
    endfunction

    function automatic bit is_supported(input logic [6:0] op);
        for (int i = 0; i < 8; i++) begin
            if (supported_op(i) == op) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic logic [31:0] random_supported();
        logic [31:0] r;
        r = $random(stim_seed);
        return {r[31:7], supported_op(int'(r[2:0]))};  // low bits reused as pick
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    task automatic check_ctrl(input decode_pkg::ctrl_word_t got,
                              input decode_pkg::ctrl_word_t exp, input int idx);
        string name;
        name = "";
        if (got.branch !== exp.branch) name = "branch";
        else if (got.jump !== exp.jump) name = "jump";
        else if (got.result_src !== exp.result_src) name = "result_src";
        else if (got.mem_write !== exp.mem_write) name = "mem_write";
        else if (got.alu_src !== exp.alu_src) name = "alu_src";
        else if (got.reg_write !== exp.reg_write) name = "reg_write";
        else if (got.alu_ctrl !== exp.alu_ctrl) name = "alu_ctrl";
        else if (got.imm !== exp.imm) name = "imm";
        else if (got.rd !== exp.rd) name = "rd";
        else if (got.rs1 !== exp.rs1) name = "rs1";
        else if (got.rs2 !== exp.rs2) name = "rs2";
        if (name != "") begin
            $display("ERR %0t: word %0d field %s wrong, got %h expected %h",
                     $time, idx, name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    // four-phase source, called right after a rising edge
    task automatic send_instr(input logic [31:0] instr);
        exp_q.push_back(ref_decode(instr));
        sent++;
        in_req_i   <= 1'b1;
        in_instr_i <= instr;
        do @(posedge clk_i); while (!in_ack_o);
        in_req_i <= 1'b0;
        do @(posedge clk_i); while (in_ack_o);
    endtask

    initial begin : stimulus
        logic [31:0] r;
        logic [6:0]  op;
        rst_n_i    = 1'b0;
        in_req_i   = 1'b0;
        in_instr_i = '0;
        @(posedge clk_i);
        repeat (3) begin
            @(posedge clk_i);
            check_bit("in_ack_o during reset", in_ack_o, 1'b0);
            check_bit("out_req_o during reset", out_req_o, 1'b0);
        end
        rst_n_i <= 1'b1;
        repeat (2) begin
            @(posedge clk_i);
            check_bit("in_ack_o after reset", in_ack_o, 1'b0);
            check_bit("out_req_o after reset", out_req_o, 1'b0);
        end

        for (int i = 0; i < 8; i++) begin      // one of each opcode
            r = $random(stim_seed);
            send_instr({r[31:7], supported_op(i)});
        end

        for (int f3 = 0; f3 < 8; f3++) begin
            for (int b = 0; b < 2; b++) begin
                r = $random(stim_seed);
                send_instr({1'b0, b[0], 5'b0, r[24:15], f3[2:0], r[11:7],
                            riscv_isa_pkg::OP_REG});
                send_instr({r[31], b[0], r[29:15], f3[2:0], r[11:7], riscv_isa_pkg::OP_IMM});
            end
        end

        repeat (N_RANDOM) send_instr(random_supported());

        repeat (N_UNKNOWN) begin
            do begin
                r  = $random(stim_seed);
                op = r[6:0];
            end while (is_supported(op));
            send_instr({r[31:7], op});
        end

        max_ack_delay <= 24;   // slow sink, lanes fill up
        repeat (N_BURST) send_instr(random_supported());

        while (received != sent) @(posedge clk_i);
        repeat (4) @(posedge clk_i);
        if (exp_q.size() == 0 && !out_req_o) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("output port still busy or words left over after the last handshake");
            $display("CHECKS FAILED");
            $fatal(1, "run ended with pending words");
        end
    end

    // four-phase sink with random ack delay
    initial begin : receiver
        decode_pkg::ctrl_word_t got;
        int delay;
        out_ack_i = 1'b0;
        forever begin
            @(posedge clk_i);
            if (out_req_o) begin
                got = out_ctrl_o;
                if (exp_q.size() == 0) begin
                    $display("output port delivered a word that was never sent");
                    $display("CHECKS FAILED");
                    $fatal(1, "unexpected output word");
                end else begin
                    check_ctrl(got, exp_q.pop_front(), received);
                    delay = $unsigned($random(ack_seed)) % (max_ack_delay + 1);
                    repeat (delay) @(posedge clk_i);
                    out_ack_i <= 1'b1;
                    do @(posedge clk_i); while (out_req_o);
                    out_ack_i <= 1'b0;
                    received++;
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("output port stopped delivering, %0d of %0d words received", received, sent);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog timeout");
    end

endmodule

//--- files.f
+incdir+verif
verilog/riscv_isa_pkg.sv
verilog/decode_pkg.sv
verilog/main_decoder.sv
verilog/alu_decoder.sv
verilog/imm_extender.sv
verilog/decode_lane.sv
verilog/instr_dispatcher.sv
verilog/ctrl_collector.sv
verilog/decode_unit_top.sv
verif/decode_unit_tb.sv
